//--- flist.f
+incdir+hw
hw/memAccessPkg.sv
hw/ctrlStatePkg.sv
hw/byteRam.sv
hw/ioWriteBuffer.sv
hw/memCtrl.sv
hw/memSubsys.sv
test/memSubsysTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
    --top-module memSubsysTb \
    -f flist.f \
    -o memSubsysSim

./obj_dir/memSubsysSim > sim.log
cat sim.log

if grep -qx "Test passed" sim.log; then
    exit 0
fi
exit 1

//--- test/memSubsysTb.sv
`include "mem_cfg.svh"

module memSubsysTb;
    import memAccessPkg::*;

    localparam int RAM_AW      = $clog2(`RAM_DEPTH);
    localparam int WIN_BASE    = 'h100;
    localparam int WIN_SIZE    = 256;
    localparam int NUM_PRELOAD = WIN_SIZE / 4;
    localparam int NUM_RANDOM  = 60;
    localparam int NUM_PRIO    = 8;
    localparam int NUM_STALL   = 8;
    localparam int NUM_IO      = 4;
    // random stores count twice, each one is read back
    localparam int NUM_OPS     = NUM_PRELOAD + 2 * NUM_RANDOM + 2 * NUM_PRIO + NUM_STALL + NUM_IO;
    localparam int TIMEOUT     = NUM_OPS * 12 + 64;

    logic                   clk;
    logic                   rst;
    logic                   rdy;
    logic                   instEn;
    logic [`ADDR_WIDTH-1:0] instAddr;
    logic                   instDone;
    logic [31:0]            instInst;
    logic                   dataEn;
    accessKind_t            dataKind;
    accessLen_t             dataLen;
    logic [`ADDR_WIDTH-1:0] dataAddr;
    logic [31:0]            dataWdata;
    logic                   dataDone;
    logic [31:0]            dataRdata;
    logic                   ioPop;
    logic                   ioValid;
    logic [7:0]             ioData;

    // reference model of the RAM and the I/O FIFO
    logic [7:0]             modelRam [`RAM_DEPTH];
    logic [7:0]             ioModel [$];

    logic [31:0]            lcgState;
    int                     errorCount;
    int                     checkCount;
    int                     cycleCount;

    memSubsys dut0 (
        .clk         (clk),
        .rst         (rst),
        .i_rdy       (rdy),
        .i_instEn    (instEn),
        .i_instAddr  (instAddr),
        .o_instDone  (instDone),
        .o_instInst  (instInst),
        .i_dataEn    (dataEn),
        .i_dataKind  (dataKind),
        .i_dataLen   (dataLen),
        .i_dataAddr  (dataAddr),
        .i_dataWdata (dataWdata),
        .o_dataDone  (dataDone),
        .o_dataRdata (dataRdata),
        .i_ioPop     (ioPop),
        .o_ioValid   (ioValid),
        .o_ioData    (ioData)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT) begin
            $display("timeout after %0d cycles, a request never completed", cycleCount);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic int randomBelow(input int limit);
        logic [31:0] r;
        r = nextRandom();
        return int'(r[31:16]) % limit;
    endfunction

    function automatic logic [31:0] randomWord();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = nextRandom();
        lo = nextRandom();
        return {hi[31:16], lo[31:16]};
    endfunction

    function automatic accessLen_t randomLen();
        case (randomBelow(3))
            0:       return LEN_1;
            1:       return LEN_2;
            default: return LEN_4;
        endcase
    endfunction

    // any start in the preloaded window that fits a word
    function automatic logic [`ADDR_WIDTH-1:0] randomAddr();
        return `ADDR_WIDTH'(WIN_BASE + randomBelow(WIN_SIZE - 3));
    endfunction

    // little-endian, zero-extended
    function automatic logic [31:0] modelWord(input logic [`ADDR_WIDTH-1:0] addr, input int n);
        logic [31:0]       word;
        logic [RAM_AW-1:0] idx;
        word = 32'd0;
        for (int i = 0; i < n; i++) begin
            idx = addr[RAM_AW-1:0] + RAM_AW'(i);
            word[8*i +: 8] = modelRam[idx];
        end
        return word;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // I/O region bytes go to the FIFO model, the rest to the RAM model
    task automatic applyStore(input logic [`ADDR_WIDTH-1:0] addr, input int n,
                              input logic [31:0] wdata);
        logic [RAM_AW-1:0] idx;
        for (int i = 0; i < n; i++) begin
            idx = addr[RAM_AW-1:0] + RAM_AW'(i);
            if (addr[`ADDR_WIDTH-1]) begin
                ioModel.push_back(wdata[8*i +: 8]);
            end else begin
                modelRam[idx] = wdata[8*i +: 8];
            end
        end
    endtask

    // rdy is held low for stallLen cycles, starting stallAt cycles after acceptance
    task automatic runDataReq(input accessKind_t kind, input accessLen_t len,
                              input logic [`ADDR_WIDTH-1:0] addr, input logic [31:0] wdata,
                              input int stallAt, input int stallLen,
                              output logic [31:0] rdata, output int lat);
        @(negedge clk);
        instEn    = 1'b0;
        dataEn    = 1'b1;
        dataKind  = kind;
        dataLen   = len;
        dataAddr  = addr;
        dataWdata = wdata;
        rdy       = 1'b1;
        lat       = 0;
        do begin
            @(negedge clk);
            lat++;
            rdy = !(lat > stallAt && lat <= stallAt + stallLen);
            #1;
        end while (!dataDone);
        rdata = dataRdata;
    endtask

    task automatic storeBytes(input string name, input logic [`ADDR_WIDTH-1:0] addr,
                              input accessLen_t len, input logic [31:0] wdata);
        logic [31:0] ignored;
        int          lat;
        runDataReq(STORE, len, addr, wdata, 0, 0, ignored, lat);
        checkValue({name, " latency"}, 32'(int'(len)), 32'(lat));
        applyStore(addr, int'(len), wdata);
    endtask

    task automatic loadBytes(input string name, input logic [`ADDR_WIDTH-1:0] addr,
                             input accessLen_t len, input int stallAt, input int stallLen);
        logic [31:0] rdata;
        int          lat;
        runDataReq(LOAD, len, addr, 32'd0, stallAt, stallLen, rdata, lat);
        checkValue({name, " data"}, modelWord(addr, int'(len)), rdata);
        checkValue({name, " latency"}, 32'(int'(len) + 1 + stallLen), 32'(lat));
    endtask

    task automatic fetchWord(input string name, input logic [`ADDR_WIDTH-1:0] addr);
        int lat;
        @(negedge clk);
        dataEn   = 1'b0;
        instEn   = 1'b1;
        instAddr = addr;
        rdy      = 1'b1;
        lat      = 0;
        do begin
            @(negedge clk);
            lat++;
            #1;
        end while (!instDone);
        checkValue({name, " data"}, modelWord(addr, 4), instInst);
        checkValue({name, " latency"}, 32'd5, 32'(lat));
    endtask

    // both requesters raise enable in the same cycle
    task automatic fetchWithData(input logic [`ADDR_WIDTH-1:0] fetchAddr, input accessKind_t kind,
                                 input accessLen_t len, input logic [`ADDR_WIDTH-1:0] addr,
                                 input logic [31:0] wdata);
        int          lat;
        int          dataLat;
        int          instLat;
        logic [31:0] rdata;
        logic [31:0] inst;
        logic [31:0] expData;
        expData = modelWord(addr, int'(len));
        @(negedge clk);
        instEn    = 1'b1;
        instAddr  = fetchAddr;
        dataEn    = 1'b1;
        dataKind  = kind;
        dataLen   = len;
        dataAddr  = addr;
        dataWdata = wdata;
        rdy       = 1'b1;
        lat       = 0;
        dataLat   = 0;
        instLat   = 0;
        rdata     = 32'd0;
        inst      = 32'd0;
        while (instLat == 0) begin
            @(negedge clk);
            lat++;
            if (dataLat != 0) begin
                dataEn = 1'b0;
            end
            #1;
            if (dataDone && dataLat == 0) begin
                dataLat = lat;
                rdata   = dataRdata;
            end
            if (instDone) begin
                instLat = lat;
                inst    = instInst;
            end
        end
        // the store lands before the fetch reads
        if (kind == STORE) begin
            applyStore(addr, int'(len), wdata);
            checkValue("priority store latency", 32'(int'(len)), 32'(dataLat));
        end else begin
            checkValue("priority load data", expData, rdata);
            checkValue("priority load latency", 32'(int'(len) + 1), 32'(dataLat));
        end
        checkValue("priority data first", 32'd1, 32'(dataLat != 0 && dataLat < instLat));
        checkValue("priority fetch data", modelWord(fetchAddr, 4), inst);
        checkValue("priority fetch latency", 32'(dataLat + 6), 32'(instLat));
    endtask

    task automatic popIoByte(input string name);
        logic [7:0] expByte;
        @(negedge clk);
        ioPop = 1'b1;
        #1;
        expByte = ioModel.pop_front();
        checkValue({name, " valid"}, 32'd1, 32'(ioValid));
        checkValue(name, 32'(expByte), 32'(ioData));
    endtask

    task automatic ioSequence();
        logic [`ADDR_WIDTH-1:0] lowAddr;
        logic [`ADDR_WIDTH-1:0] ioAddr;
        logic [31:0]            wdata;
        lowAddr = randomAddr();
        ioAddr  = lowAddr | {1'b1, {(`ADDR_WIDTH-1){1'b0}}};
        // one queued byte makes the word store fill the FIFO before its last byte
        storeBytes("io single store", ioAddr, LEN_1, randomWord());
        wdata = randomWord();
        applyStore(ioAddr, 4, wdata);
        @(negedge clk);
        dataEn    = 1'b1;
        dataKind  = STORE;
        dataLen   = LEN_4;
        dataAddr  = ioAddr;
        dataWdata = wdata;
        ioPop     = 1'b0;
        repeat (10) begin
            @(negedge clk);
            #1;
            checkValue("io stalled done", 32'd0, 32'(dataDone));
        end
        checkValue("io full valid", 32'd1, 32'(ioValid));
        popIoByte("io pop while stalled");
        checkValue("io stalled done", 32'd0, 32'(dataDone));
        do begin
            @(negedge clk);
            ioPop = 1'b0;
            #1;
        end while (!dataDone);
        @(negedge clk);
        dataEn = 1'b0;
        repeat (4) popIoByte("io drain");
        @(negedge clk);
        ioPop = 1'b0;
        #1;
        checkValue("io empty", 32'd0, 32'(ioValid));
        loadBytes("io ram unchanged", lowAddr, LEN_4, 0, 0);
    endtask

    initial begin
        logic [`ADDR_WIDTH-1:0] addr;
        accessLen_t             len;
        accessKind_t            kind;
        clk        = 1'b0;
        rst        = 1'b1;
        rdy        = 1'b1;
        instEn     = 1'b0;
        instAddr   = '0;
        dataEn     = 1'b0;
        dataKind   = LOAD;
        dataLen    = LEN_1;
        dataAddr   = '0;
        dataWdata  = 32'd0;
        ioPop      = 1'b0;
        lcgState   = 32'd28413;
        errorCount = 0;
        checkCount = 0;
        cycleCount = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        checkValue("reset inst done", 32'd0, 32'(instDone));
        checkValue("reset data done", 32'd0, 32'(dataDone));
        checkValue("reset io valid", 32'd0, 32'(ioValid));

        // known contents for the whole address window
        for (int i = 0; i < NUM_PRELOAD; i++) begin
            storeBytes("preload", `ADDR_WIDTH'(WIN_BASE + 4 * i), LEN_4, randomWord());
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            addr = randomAddr();
            len  = randomLen();
            case (randomBelow(3))
                0: fetchWord("random fetch", addr);
                1: loadBytes("random load", addr, len, 0, 0);
                default: begin
                    storeBytes("random store", addr, len, randomWord());
                    loadBytes("store readback", addr, len, 0, 0);
                end
            endcase
        end

        for (int i = 0; i < NUM_PRIO; i++) begin
            kind = (randomBelow(2) == 0) ? LOAD : STORE;
            fetchWithData(randomAddr(), kind, randomLen(), randomAddr(), randomWord());
        end

        for (int i = 0; i < NUM_STALL; i++) begin
            addr = randomAddr();
            len  = randomLen();
            // the stall may begin in any byte stage, the done cycle included
            loadBytes("stalled load", addr, len, randomBelow(int'(len) + 1), 1 + randomBelow(4));
        end

        ioSequence();

        @(negedge clk);
        instEn = 1'b0;
        dataEn = 1'b0;
        $display("checks %0d errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- hw/memSubsys.sv
`include "mem_cfg.svh"

module memSubsys (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_rdy,

    input  logic                        i_instEn,
    input  logic [`ADDR_WIDTH-1:0]      i_instAddr,
    output logic                        o_instDone,
    output logic [31:0]                 o_instInst,

    input  logic                        i_dataEn,
    input  memAccessPkg::accessKind_t   i_dataKind,
    input  memAccessPkg::accessLen_t    i_dataLen,
    input  logic [`ADDR_WIDTH-1:0]      i_dataAddr,
    input  logic [31:0]                 i_dataWdata,
    output logic                        o_dataDone,
    output logic [31:0]                 o_dataRdata,

    input  logic                        i_ioPop,
    output logic                        o_ioValid,
    output logic [7:0]                  o_ioData
);
    import memAccessPkg::*;

    memOp_t                 memOp;
    logic [`ADDR_WIDTH-1:0] memAddr;
    logic [7:0]             memWdata;
    logic [7:0]             memRdata;
    logic                   ramWe;
    logic                   ioFull;

    memCtrl ctrl0 (
        .clk         (clk),
        .rst         (rst),
        .i_rdy       (i_rdy),
        .i_ioFull    (ioFull),
        .i_memRdata  (memRdata),
        .i_instEn    (i_instEn),
        .i_instAddr  (i_instAddr),
        .i_dataEn    (i_dataEn),
        .i_dataKind  (i_dataKind),
        .i_dataLen   (i_dataLen),
        .i_dataAddr  (i_dataAddr),
        .i_dataWdata (i_dataWdata),
        .o_memOp     (memOp),
        .o_memAddr   (memAddr),
        .o_memWdata  (memWdata),
        .o_instDone  (o_instDone),
        .o_instInst  (o_instInst),
        .o_dataDone  (o_dataDone),
        .o_dataRdata (o_dataRdata)
    );

    ioWriteBuffer ioBuf0 (
        .clk        (clk),
        .rst        (rst),
        .i_memOp    (memOp),
        .i_memAddr  (memAddr),
        .i_memWdata (memWdata),
        .i_ioPop    (i_ioPop),
        .o_ramWe    (ramWe),
        .o_ioFull   (ioFull),
        .o_ioValid  (o_ioValid),
        .o_ioData   (o_ioData)
    );

    // RAM sees only the low address bits
    byteRam ram0 (
        .clk     (clk),
        .i_we    (ramWe),
        .i_addr  (memAddr[$clog2(`RAM_DEPTH)-1:0]),
        .i_wdata (memWdata),
        .o_rdata (memRdata)
    );

endmodule

//--- hw/memCtrl.sv
`include "mem_cfg.svh"

module memCtrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_rdy,
    input  logic                        i_ioFull,
    input  logic [7:0]                  i_memRdata,

    input  logic                        i_instEn,
    input  logic [`ADDR_WIDTH-1:0]      i_instAddr,

    input  logic                        i_dataEn,
    input  memAccessPkg::accessKind_t   i_dataKind,
    input  memAccessPkg::accessLen_t    i_dataLen,
    input  logic [`ADDR_WIDTH-1:0]      i_dataAddr,
    input  logic [31:0]                 i_dataWdata,

    output memAccessPkg::memOp_t        o_memOp,
    output logic [`ADDR_WIDTH-1:0]      o_memAddr,
    output logic [7:0]                  o_memWdata,

    output logic                        o_instDone,
    output logic [31:0]                 o_instInst,
    output logic                        o_dataDone,
    output logic [31:0]                 o_dataRdata
);
    import memAccessPkg::*;
    import ctrlStatePkg::*;

    ctrlState_t             state;
    byteStage_t             stage;
    byteStage_t             nextStage;

    // request payload, latched on accept
    logic [`ADDR_WIDTH-1:0] baseAddr;
    accessLen_t             len;
    logic [31:0]            wdata;
    logic [23:0]            asmData;

    logic                   advance;
    logic                   lastByte;
    logic [1:0]             stageIdx;
    logic [1:0]             lastIdx;
    logic [1:0]             byteIdx;

    // global stall or full I/O FIFO freezes everything
    assign advance  = i_rdy && !i_ioFull;

    assign stageIdx = stage[1:0];
    assign lastIdx  = 2'(len - 3'd1);
    assign lastByte = (stage != STAGE_DONE) && (({1'b0, stageIdx} + 3'd1) == len);

    // while stalled, keep addressing the byte the next capture expects
    always_comb begin
        if (stage == STAGE_DONE) begin
            byteIdx = lastIdx;
        end else if (advance || stage == STAGE_0) begin
            byteIdx = stageIdx;
        end else begin
            byteIdx = stageIdx - 2'd1;
        end
    end

    always_comb begin
        case (stage)
            STAGE_0: nextStage = STAGE_1;
            STAGE_1: nextStage = STAGE_2;
            STAGE_2: nextStage = STAGE_3;
            default: nextStage = STAGE_DONE;
        endcase
        if (lastByte) begin
            nextStage = STAGE_DONE;
        end
    end

    // RAM-side bus
    assign o_memAddr  = baseAddr + `ADDR_WIDTH'(byteIdx);
    assign o_memWdata = wdata[{byteIdx, 3'b000} +: 8];
    assign o_memOp    = (state == STORE_DATA && advance) ? MEM_WRITE : MEM_READ;

    // done cycle merges the live RAM byte with the assembled ones
    assign o_instDone = advance && (state == FETCH) && (stage == STAGE_DONE);
    assign o_instInst = o_instDone ? {i_memRdata, asmData} : 32'd0;

    always_comb begin
        o_dataDone  = 1'b0;
        o_dataRdata = 32'd0;
        if (advance) begin
            if (state == LOAD_DATA && stage == STAGE_DONE) begin
                o_dataDone = 1'b1;
                case (len)
                    LEN_1:   o_dataRdata = {24'd0, i_memRdata};
                    LEN_2:   o_dataRdata = {16'd0, i_memRdata, asmData[7:0]};
                    default: o_dataRdata = {i_memRdata, asmData};
                endcase
            end else if (state == STORE_DATA && lastByte) begin
                o_dataDone = 1'b1;
            end
        end
    end

    // state and stage sequencing
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            stage <= STAGE_0;
        end else if (advance) begin
            case (state)
                IDLE: begin
                    stage <= STAGE_0;
                    // data port wins a tie
                    if (i_dataEn) begin
                        state <= (i_dataKind == STORE) ? STORE_DATA : LOAD_DATA;
                    end else if (i_instEn) begin
                        state <= FETCH;
                    end
                end
                FETCH,
                LOAD_DATA: begin
                    if (stage == STAGE_DONE) begin
                        state <= IDLE;
                        stage <= STAGE_0;
                    end else begin
                        stage <= nextStage;
                    end
                end
                STORE_DATA: begin
                    if (lastByte) begin
                        state <= IDLE;
                        stage <= STAGE_0;
                    end else begin
                        stage <= nextStage;
                    end
                end
                default: begin
                    state <= IDLE;
                    stage <= STAGE_0;
                end
            endcase
        end
    end

    // payload and read assembly
    always_ff @(posedge clk) begin
        if (advance) begin
            if (state == IDLE) begin
                if (i_dataEn) begin
                    baseAddr <= i_dataAddr;
                    len      <= i_dataLen;
                    wdata    <= i_dataWdata;
                end else begin
                    baseAddr <= i_instAddr;
                    // a fetch is always a full word
                    len      <= LEN_4;
                end
            end else if (state != STORE_DATA && stage != STAGE_0 && stage != STAGE_DONE) begin
                // RAM returns the byte issued one stage earlier
                asmData[{stageIdx - 2'd1, 3'b000} +: 8] <= i_memRdata;
            end
        end
    end

endmodule

//--- hw/ioWriteBuffer.sv
`include "mem_cfg.svh"

module ioWriteBuffer (
    input  logic                     clk,
    input  logic                     rst,
    input  memAccessPkg::memOp_t     i_memOp,
    input  logic [`ADDR_WIDTH-1:0]   i_memAddr,
    input  logic [7:0]               i_memWdata,
    input  logic                     i_ioPop,
    output logic                     o_ramWe,
    output logic                     o_ioFull,
    output logic                     o_ioValid,
    output logic [7:0]               o_ioData
);
    import memAccessPkg::*;

    logic [7:0]               fifoMem [`IO_DEPTH];
    logic [`IO_PTR_WIDTH-1:0] wrPtr;
    logic [`IO_PTR_WIDTH-1:0] rdPtr;
    logic [`IO_PTR_WIDTH:0]   count;
    logic                     isIo;
    logic                     push;
    logic                     pop;

    // region decode
    assign isIo    = i_memAddr[`ADDR_WIDTH-1];
    assign o_ramWe = (i_memOp == MEM_WRITE) && !isIo;

    assign o_ioFull  = (count == (`IO_PTR_WIDTH+1)'(`IO_DEPTH));
    assign o_ioValid = (count != '0);
    assign o_ioData  = fifoMem[rdPtr];

    assign push = (i_memOp == MEM_WRITE) && isIo && !o_ioFull;
    assign pop  = i_ioPop && o_ioValid;

    always_ff @(posedge clk) begin
        if (push) begin
            fifoMem[wrPtr] <= i_memWdata;
        end
    end

    // pointers wrap since depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hw/byteRam.sv
`include "mem_cfg.svh"

module byteRam (
    input  logic                          clk,
    input  logic                          i_we,
    input  logic [$clog2(`RAM_DEPTH)-1:0] i_addr,
    input  logic [7:0]                    i_wdata,
    output logic [7:0]                    o_rdata
);

    logic [7:0] mem [`RAM_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
    end

    // registered read, returns old data on a same-cycle write
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_addr];
    end

endmodule

//--- hw/ctrlStatePkg.sv
package ctrlStatePkg;

    // which requester owns the RAM bus
    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        FETCH      = 2'd1,
        LOAD_DATA  = 2'd2,
        STORE_DATA = 2'd3
    } ctrlState_t;

    // low two bits give the byte being issued
    typedef enum logic [2:0] {
        STAGE_0    = 3'd0,
        STAGE_1    = 3'd1,
        STAGE_2    = 3'd2,
        STAGE_3    = 3'd3,
        STAGE_DONE = 3'd4
    } byteStage_t;

endpackage

//--- hw/memAccessPkg.sv
package memAccessPkg;

    // direction of a data port request
    typedef enum logic {
        LOAD  = 1'b0,
        STORE = 1'b1
    } accessKind_t;

    // value is the byte count of the access
    typedef enum logic [2:0] {
        LEN_1 = 3'd1,
        LEN_2 = 3'd2,
        LEN_4 = 3'd4
    } accessLen_t;

    // opcode on the byte-wide RAM bus
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } memOp_t;

endpackage

//--- hw/mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// byte address, top bit selects the I/O region
`define ADDR_WIDTH 17

// RAM size in bytes, indexed by the low address bits
`define RAM_DEPTH 4096

// output FIFO for I/O stores
`define IO_DEPTH 4

// must match IO_DEPTH
`define IO_PTR_WIDTH 2

`endif
